//--- include/vdp_cfg.svh
// --------------------------------------------------------------------------
// VDP register block constants
// Palette depth is fixed at 16 entries of 3 bits per channel
// Reset palette packs entry n of a channel at bits [3n+2:3n]
// --------------------------------------------------------------------------
`ifndef VDP_CFG_SVH
`define VDP_CFG_SVH

`define VDP_ID      5'd2     // Chip identity reported in S#1
`define PAL_ENTRIES 16
`define PAL_IDX_W   4
`define STATUS_FILL 8'hFF    // Returned for unsupported status numbers

// Power-up colors, entry 15 in the top bits
`define PAL_RESET_R 48'hF69D_7655_A640
`define PAL_RESET_G 48'hD0BB_11A5_18C0
`define PAL_RESET_B 48'hF696_9AEB_E640

`endif

//--- source/vdp_reg_pkg.sv
// --------------------------------------------------------------------------
// Register numbers and CPU port encodings
// Pointer bit 5 marks a command engine register, not handled here
// --------------------------------------------------------------------------
package vdp_reg_pkg;

  typedef logic [5:0] reg_num_t;
  typedef logic [7:0] reg_byte_t;

  typedef enum logic [1:0] {
    PORT_VRAM     = 2'd0,
    PORT_CTRL     = 2'd1,
    PORT_PALETTE  = 2'd2,
    PORT_INDIRECT = 2'd3
  } port_t;

  localparam reg_num_t R_MODE0      = 6'd0;
  localparam reg_num_t R_MODE1      = 6'd1;
  localparam reg_num_t R_NAME       = 6'd2;
  localparam reg_num_t R_COLOR_LO   = 6'd3;
  localparam reg_num_t R_PAT_GEN    = 6'd4;
  localparam reg_num_t R_SP_ATR_LO  = 6'd5;
  localparam reg_num_t R_SP_GEN     = 6'd6;
  localparam reg_num_t R_FRAME      = 6'd7;
  localparam reg_num_t R_MODE2      = 6'd8;
  localparam reg_num_t R_MODE3      = 6'd9;
  localparam reg_num_t R_COLOR_HI   = 6'd10;
  localparam reg_num_t R_SP_ATR_HI  = 6'd11;
  localparam reg_num_t R_BLINK_COL  = 6'd12;
  localparam reg_num_t R_BLINK_PER  = 6'd13;
  localparam reg_num_t R_STATUS_SEL = 6'd15;
  localparam reg_num_t R_PAL_IDX    = 6'd16;
  localparam reg_num_t R_INDIRECT   = 6'd17;
  localparam reg_num_t R_ADJUST     = 6'd18;
  localparam reg_num_t R_HSYNC_LINE = 6'd19;
  localparam reg_num_t R_VSTART     = 6'd23;
  localparam reg_num_t R_YJK        = 6'd25;
  localparam reg_num_t R_HSCROLL_HI = 6'd26;
  localparam reg_num_t R_HSCROLL_LO = 6'd27;

endpackage

//--- source/vdp_mode_pkg.sv
// --------------------------------------------------------------------------
// Display mode types
// disp_mode_t is {R0[3:1], R1[3], R1[4]}
// --------------------------------------------------------------------------
package vdp_mode_pkg;

  typedef logic [4:0] disp_mode_t;

  typedef struct packed {
    logic text1;
    logic text1q;
    logic text2;
    logic multi;
    logic multiq;
    logic graphic1;
    logic graphic2;
    logic graphic3;
    logic graphic4;
    logic graphic5;
    logic graphic6;
    logic graphic7;
    logic is_high_res;   // 512 dot wide modes
    logic sp_mode2;
  } mode_flags_t;

endpackage

//--- source/cpu_port_decoder.sv
// --------------------------------------------------------------------------
// CPU access cycle and register write sequencing
// req is a single-cycle strobe, ack follows it by one cycle
// Port 1 bytes pair up; a port 1 read restarts the pairing
// VRAM port accesses are acknowledged and otherwise ignored
// --------------------------------------------------------------------------
module cpu_port_decoder (
  input  logic                   RESET,
  input  logic                   CLK21M,
  input  logic                   req,
  input  logic                   wrt,
  input  vdp_reg_pkg::port_t     port,
  input  vdp_reg_pkg::reg_byte_t data_in,
  output logic                   ack,
  output logic                   reg_wr_valid,
  output vdp_reg_pkg::reg_num_t  reg_wr_num,
  output vdp_reg_pkg::reg_byte_t reg_wr_data
);
  import vdp_reg_pkg::*;

  logic      first_byte;   // Next port 1 write is the data byte
  reg_byte_t p1_buf;
  reg_num_t  r17_ptr;
  logic      r17_inc;
  logic      wr_ctrl;
  logic      wr_ind;

  assign wr_ctrl = req && wrt && (port == PORT_CTRL);
  assign wr_ind  = req && wrt && (port == PORT_INDIRECT);

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      ack          <= 1'b0;
      reg_wr_valid <= 1'b0;
      first_byte   <= 1'b1;
      r17_ptr      <= '0;
      r17_inc      <= 1'b0;
    end else begin
      ack          <= req;
      reg_wr_valid <= 1'b0;
      if (req && !wrt && port == PORT_CTRL) begin
        first_byte <= 1'b1;
      end else if (wr_ctrl) begin
        first_byte <= !first_byte;
        // Bit 7 set on the second byte selects a register, else VRAM setup
        if (!first_byte && data_in[7]) begin
          reg_wr_valid <= 1'b1;
        end
      end else if (wr_ind) begin
        reg_wr_valid <= (r17_ptr != R_INDIRECT);   // R17 can't write itself
        if (r17_inc) begin
          r17_ptr <= r17_ptr + 1'b1;
        end
      end

      // R17 snoop
      if (reg_wr_valid && reg_wr_num == R_INDIRECT) begin
        r17_ptr <= reg_wr_data[5:0];
        r17_inc <= ~reg_wr_data[7];
      end
    end
  end

  // Write payload
  always_ff @(posedge RESET) begin
    if (wr_ctrl && first_byte) begin
      p1_buf <= data_in;
    end else if (wr_ctrl) begin
      reg_wr_num  <= data_in[5:0];
      reg_wr_data <= p1_buf;
    end else if (wr_ind) begin
      reg_wr_num  <= r17_ptr;
      reg_wr_data <= data_in;
    end
  end

endmodule

//--- source/control_regs.sv
// --------------------------------------------------------------------------
// Control registers R0-R27
// Mode bits, display enable, R25 SP2 and R26 take effect on hsync only
// R16 and R17 are held by the palette writer and the port decoder
// --------------------------------------------------------------------------
module control_regs (
  input  logic                    RESET,
  input  logic                    CLK21M,
  input  logic                    hsync,
  input  logic                    field,
  input  logic                    reg_wr_valid,
  input  vdp_reg_pkg::reg_num_t   reg_wr_num,
  input  vdp_reg_pkg::reg_byte_t  reg_wr_data,
  output vdp_mode_pkg::disp_mode_t disp_mode,
  output logic                    disp_on,
  output logic                    r0_hsync_int_en,
  output logic                    r1_sp_size,
  output logic                    r1_sp_zoom,
  output logic                    r1_vsync_int_en,
  output logic [6:0]              name_addr,
  output logic [10:0]             color_addr,
  output logic [5:0]              pat_gen_addr,
  output logic [9:0]              sp_atr_addr,
  output logic [5:0]              sp_gen_addr,
  output logic [7:0]              frame_color,
  output logic                    r8_sp_off,
  output logic                    r8_col0_on,
  output logic                    r9_pal_mode,
  output logic                    r9_interlace,
  output logic                    r9_y_dots,
  output logic [7:0]              blink_mode,
  output logic [7:0]              blink_period,
  output logic [7:0]              adjust,
  output logic [7:0]              hsync_int_line,
  output logic [7:0]              vstart_line,
  output logic                    r25_yae,
  output logic                    r25_yjk,
  output logic                    r25_msk,
  output logic                    r25_sp2,
  output logic [8:0]              h_scroll,
  output logic [3:0]              status_sel
);
  import vdp_reg_pkg::*;
  import vdp_mode_pkg::*;

  disp_mode_t mode_st;      // Staged until hsync
  logic       disp_on_st;
  logic       sp2_st;
  logic [5:0] hs_hi_st;
  logic [6:0] r2_name;
  logic       two_page;
  logic       is_bitmap;

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      mode_st         <= '0;
      disp_on_st      <= 1'b0;
      sp2_st          <= 1'b0;
      hs_hi_st        <= '0;
      disp_mode       <= '0;
      disp_on         <= 1'b0;
      r25_sp2         <= 1'b0;
      h_scroll        <= '0;
      r2_name         <= '0;
      two_page        <= 1'b0;
      r0_hsync_int_en <= 1'b0;
      r1_sp_size      <= 1'b0;
      r1_sp_zoom      <= 1'b0;
      r1_vsync_int_en <= 1'b0;
      color_addr      <= '0;
      pat_gen_addr    <= '0;
      sp_atr_addr     <= '0;
      sp_gen_addr     <= '0;
      frame_color     <= '0;
      r8_sp_off       <= 1'b0;
      r8_col0_on      <= 1'b0;
      r9_pal_mode     <= 1'b0;
      r9_interlace    <= 1'b0;
      r9_y_dots       <= 1'b0;
      blink_mode      <= '0;
      blink_period    <= '0;
      adjust          <= '0;
      hsync_int_line  <= '0;
      vstart_line     <= '0;
      r25_yae         <= 1'b0;
      r25_yjk         <= 1'b0;
      r25_msk         <= 1'b0;
      status_sel      <= '0;
    end else begin
      // Full 6-bit compare, so command registers (bit 5) match nothing
      if (reg_wr_valid) begin
        case (reg_wr_num)
          R_MODE0: begin
            mode_st[4:2]    <= reg_wr_data[3:1];
            r0_hsync_int_en <= reg_wr_data[4];
          end
          R_MODE1: begin
            r1_sp_zoom      <= reg_wr_data[0];
            r1_sp_size      <= reg_wr_data[1];
            mode_st[1:0]    <= {reg_wr_data[3], reg_wr_data[4]};
            r1_vsync_int_en <= reg_wr_data[5];
            disp_on_st      <= reg_wr_data[6];
          end
          R_NAME:       r2_name           <= reg_wr_data[6:0];
          R_COLOR_LO:   color_addr[7:0]   <= reg_wr_data;
          R_PAT_GEN:    pat_gen_addr      <= reg_wr_data[5:0];
          R_SP_ATR_LO:  sp_atr_addr[7:0]  <= reg_wr_data;
          R_SP_GEN:     sp_gen_addr       <= reg_wr_data[5:0];
          R_FRAME:      frame_color       <= reg_wr_data;
          R_MODE2: begin
            r8_sp_off  <= reg_wr_data[1];
            r8_col0_on <= reg_wr_data[5];
          end
          R_MODE3: begin
            r9_pal_mode  <= reg_wr_data[1];
            two_page     <= reg_wr_data[2];
            r9_interlace <= reg_wr_data[3];
            r9_y_dots    <= reg_wr_data[7];
          end
          R_COLOR_HI:   color_addr[10:8]  <= reg_wr_data[2:0];
          R_SP_ATR_HI:  sp_atr_addr[9:8]  <= reg_wr_data[1:0];
          R_BLINK_COL:  blink_mode        <= reg_wr_data;
          R_BLINK_PER:  blink_period      <= reg_wr_data;
          R_STATUS_SEL: status_sel        <= reg_wr_data[3:0];
          R_ADJUST:     adjust            <= reg_wr_data;
          R_HSYNC_LINE: hsync_int_line    <= reg_wr_data;
          R_VSTART:     vstart_line       <= reg_wr_data;
          R_YJK: begin
            r25_msk <= reg_wr_data[1];
            r25_yjk <= reg_wr_data[3];
            r25_yae <= reg_wr_data[4];
            sp2_st  <= reg_wr_data[0];
          end
          R_HSCROLL_HI: hs_hi_st          <= reg_wr_data[5:0];
          R_HSCROLL_LO: h_scroll[2:0]     <= reg_wr_data[2:0];
          default: ;
        endcase
      end

      if (hsync) begin
        disp_mode     <= mode_st;
        disp_on       <= disp_on_st;
        r25_sp2       <= sp2_st;
        h_scroll[8:3] <= hs_hi_st;
      end
    end
  end

  // Two-page bitmap display swaps name table page with the field
  assign is_bitmap = disp_mode[4] || (disp_mode[4:2] == 3'b011);
  assign name_addr = (is_bitmap && two_page) ? {r2_name[6], field, r2_name[4:0]} : r2_name;

endmodule

//--- source/display_mode_decoder.sv
// --------------------------------------------------------------------------
// One-hot display mode flags from the latched mode bits
// Purely combinational; unlisted codes give no screen mode flag
// --------------------------------------------------------------------------
module display_mode_decoder (
  input  vdp_mode_pkg::disp_mode_t  disp_mode,
  output vdp_mode_pkg::mode_flags_t flags
);
  import vdp_mode_pkg::*;

  always_comb begin
    flags = '0;
    case (disp_mode)
      5'b00000: flags.graphic1 = 1'b1;
      5'b00001: flags.text1    = 1'b1;
      5'b00010: flags.multi    = 1'b1;
      5'b00100: flags.graphic2 = 1'b1;
      5'b00101: flags.text1q   = 1'b1;
      5'b00110: flags.multiq   = 1'b1;
      5'b01000: flags.graphic3 = 1'b1;
      5'b01001: flags.text2    = 1'b1;
      5'b01100: flags.graphic4 = 1'b1;
      5'b10000: flags.graphic5 = 1'b1;
      5'b10100: flags.graphic6 = 1'b1;
      5'b11100: flags.graphic7 = 1'b1;
      default: ;
    endcase
    // G5/G6 are the 512 dot modes
    flags.is_high_res = (disp_mode[4:3] == 2'b10) && (disp_mode[1:0] == 2'b00);
    // G3 and above use sprite mode 2
    flags.sp_mode2 = flags.graphic3 || flags.graphic4 || flags.graphic5 ||
                     flags.graphic6 || flags.graphic7;
  end

endmodule

//--- source/palette_writer.sv
// --------------------------------------------------------------------------
// Palette write path and 16 x 9-bit palette memory
// Port 2 takes red/blue first, then green; R16 sets the index
// A staged entry commits in dot state 01 or 10; a newer pair overwrites it
// The read port is registered and holds while an entry commits
// --------------------------------------------------------------------------
`include "vdp_cfg.svh"

module palette_writer (
  input  logic                   RESET,
  input  logic                   CLK21M,
  input  logic                   req,
  input  logic                   wrt,
  input  vdp_reg_pkg::port_t     port,
  input  vdp_reg_pkg::reg_byte_t data_in,
  input  logic                   reg_wr_valid,
  input  vdp_reg_pkg::reg_num_t  reg_wr_num,
  input  vdp_reg_pkg::reg_byte_t reg_wr_data,
  input  logic [1:0]             dotstate,
  input  logic [`PAL_IDX_W-1:0]  pal_addr,
  output logic [2:0]             pal_r,
  output logic [2:0]             pal_g,
  output logic [2:0]             pal_b
);
  import vdp_reg_pkg::*;

  logic                  rb_phase;    // Expecting the red/blue byte
  logic [`PAL_IDX_W-1:0] pal_idx;     // R16
  logic [`PAL_IDX_W-1:0] wr_idx;
  logic [2:0]            st_r;
  logic [2:0]            st_g;
  logic [2:0]            st_b;
  logic                  st_valid;
  logic                  commit_ready;
  logic                  commit;
  logic                  wr_pal;
  logic [8:0]            pal_mem [`PAL_ENTRIES];

  assign wr_pal       = req && wrt && (port == PORT_PALETTE);
  assign commit_ready = (dotstate == 2'b01) || (dotstate == 2'b10);
  assign commit       = st_valid && commit_ready;

  initial begin
    for (int i = 0; i < `PAL_ENTRIES; i++) begin
      pal_mem[i] = {3'(`PAL_RESET_R >> (3 * i)),
                    3'(`PAL_RESET_G >> (3 * i)),
                    3'(`PAL_RESET_B >> (3 * i))};
    end
  end

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      rb_phase <= 1'b1;
      pal_idx  <= '0;
      st_valid <= 1'b0;
    end else begin
      if (commit) begin
        st_valid <= 1'b0;
      end
      if (wr_pal) begin
        rb_phase <= !rb_phase;
        if (!rb_phase) begin
          st_valid <= 1'b1;
          pal_idx  <= pal_idx + 1'b1;   // Wraps at 16
        end
      end
      // R16 snoop, also restarts the byte pair
      if (reg_wr_valid && reg_wr_num == R_PAL_IDX) begin
        pal_idx  <= reg_wr_data[`PAL_IDX_W-1:0];
        rb_phase <= 1'b1;
      end
    end
  end

  // Staged entry
  always_ff @(posedge RESET) begin
    if (wr_pal && rb_phase) begin
      st_r <= data_in[6:4];
      st_b <= data_in[2:0];
    end else if (wr_pal) begin
      st_g   <= data_in[2:0];
      wr_idx <= pal_idx;
    end
  end

  always_ff @(posedge RESET) begin
    if (commit) begin
      pal_mem[wr_idx] <= {st_r, st_g, st_b};
    end else begin
      {pal_r, pal_g, pal_b} <= pal_mem[pal_addr];
    end
  end

endmodule

//--- source/status_reader.sv
// --------------------------------------------------------------------------
// Status register read data
// Only S#1 and S#2 are implemented, others read back as fill
// read_data holds until the next port 1 read
// --------------------------------------------------------------------------
`include "vdp_cfg.svh"

module status_reader (
  input  logic                   RESET,
  input  logic                   CLK21M,
  input  logic                   req,
  input  logic                   wrt,
  input  vdp_reg_pkg::port_t     port,
  input  logic [3:0]             status_sel,
  input  logic                   vd,
  input  logic                   hd,
  input  logic                   field,
  output vdp_reg_pkg::reg_byte_t read_data
);
  import vdp_reg_pkg::*;

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      read_data <= '0;
    end else if (req && !wrt && port == PORT_CTRL) begin
      case (status_sel)
        4'd1:    read_data <= {2'b00, `VDP_ID, 1'b0};
        4'd2:    read_data <= {1'b0, vd, hd, 1'b0, 2'b11, field, 1'b0};   // S#2
        default: read_data <= `STATUS_FILL;
      endcase
    end
  end

endmodule

//--- source/vdp_register.sv
// --------------------------------------------------------------------------
// VDP CPU register block, top level
// Submodule ports share names with the top, so instances connect by name
// --------------------------------------------------------------------------
`include "vdp_cfg.svh"

module vdp_register (
  input  logic                      RESET,
  input  logic                      CLK21M,
  input  logic                      req,
  input  logic                      wrt,
  input  vdp_reg_pkg::port_t        port,
  input  vdp_reg_pkg::reg_byte_t    data_in,
  output logic                      ack,
  output vdp_reg_pkg::reg_byte_t    read_data,
  input  logic                      hsync,
  input  logic                      field,
  input  logic                      vd,
  input  logic                      hd,
  input  logic [1:0]                dotstate,
  input  logic [`PAL_IDX_W-1:0]     pal_addr,
  output logic [2:0]                pal_r,
  output logic [2:0]                pal_g,
  output logic [2:0]                pal_b,
  output vdp_mode_pkg::mode_flags_t flags,
  output logic                      disp_on,
  output logic                      r0_hsync_int_en,
  output logic                      r1_sp_size,
  output logic                      r1_sp_zoom,
  output logic                      r1_vsync_int_en,
  output logic [6:0]                name_addr,
  output logic [10:0]               color_addr,
  output logic [5:0]                pat_gen_addr,
  output logic [9:0]                sp_atr_addr,
  output logic [5:0]                sp_gen_addr,
  output logic [7:0]                frame_color,
  output logic                      r8_sp_off,
  output logic                      r8_col0_on,
  output logic                      r9_pal_mode,
  output logic                      r9_interlace,
  output logic                      r9_y_dots,
  output logic [7:0]                blink_mode,
  output logic [7:0]                blink_period,
  output logic [7:0]                adjust,
  output logic [7:0]                hsync_int_line,
  output logic [7:0]                vstart_line,
  output logic                      r25_yae,
  output logic                      r25_yjk,
  output logic                      r25_msk,
  output logic                      r25_sp2,
  output logic [8:0]                h_scroll
);
  import vdp_reg_pkg::*;
  import vdp_mode_pkg::*;

  // Register write strobe shared by the register file and palette
  logic       reg_wr_valid;
  reg_num_t   reg_wr_num;
  reg_byte_t  reg_wr_data;
  disp_mode_t disp_mode;
  logic [3:0] status_sel;

  cpu_port_decoder u_cpu_port_decoder (.*);

  control_regs u_control_regs (.*);

  display_mode_decoder u_display_mode_decoder (.*);

  palette_writer u_palette_writer (.*);

  status_reader u_status_reader (.*);

endmodule

//--- bench/tb_clock_gen.sv
// --------------------------------------------------------------------------
// Clock and reset for the VDP register testbench
// RESET carries the 20 unit clock, CLK21M the active high reset
// Reset drops on the falling edge after the third rising edge
// --------------------------------------------------------------------------
module tb_clock_gen (
  output logic RESET,
  output logic CLK21M
);

  initial begin
    RESET  = 1'b0;
    CLK21M = 1'b1;
    repeat (3) @(posedge RESET);
    @(negedge RESET);
    CLK21M = 1'b0;
  end

  always #10 RESET = ~RESET;   // Period 20

endmodule

//--- bench/tb_vdp_register.sv
// --------------------------------------------------------------------------
// Testbench for the VDP register block
// Stimulus from a 32-bit Fibonacci LFSR, inputs change on the falling edge
// The model keeps written register bytes, the hsync latch, R16, R17 and
// the palette; the reset palette is expected as packed in the config header
// Random mode codes are limited to the twelve defined screen modes
// --------------------------------------------------------------------------
`include "vdp_cfg.svh"

module tb_vdp_register;
  import vdp_reg_pkg::*;
  import vdp_mode_pkg::*;

  localparam int N_DIRECT = 40;
  localparam int N_MODE   = 12;
  localparam int N_IND    = 6;
  localparam int N_PAL    = 20;
  localparam int N_STAT   = 6;
  // CPU accesses, hsync pulses, commit waits and palette reads
  localparam int N_TRANS  = 6 * N_DIRECT + 7 * N_MODE + 6 * N_IND + 8 + 3 * N_PAL
                          + 2 * `PAL_ENTRIES + 7 * (N_STAT + 2);
  localparam int TIMEOUT  = N_TRANS * 12 + 100;

  logic                  RESET;
  logic                  CLK21M;
  logic                  req;
  logic                  wrt;
  port_t                 port;
  reg_byte_t             data_in;
  logic                  hsync;
  logic                  field;
  logic                  vd;
  logic                  hd;
  logic [1:0]            dotstate;
  logic [`PAL_IDX_W-1:0] pal_addr;
  logic                  ack;
  reg_byte_t             read_data;
  logic [2:0]            pal_r, pal_g, pal_b;
  mode_flags_t           flags;
  logic                  disp_on, r0_hsync_int_en, r1_sp_size, r1_sp_zoom, r1_vsync_int_en;
  logic [6:0]            name_addr;
  logic [10:0]           color_addr;
  logic [5:0]            pat_gen_addr, sp_gen_addr;
  logic [9:0]            sp_atr_addr;
  logic [7:0]            frame_color, blink_mode, blink_period;
  logic [7:0]            adjust, hsync_int_line, vstart_line;
  logic                  r8_sp_off, r8_col0_on, r9_pal_mode, r9_interlace, r9_y_dots;
  logic                  r25_yae, r25_yjk, r25_msk, r25_sp2;
  logic [8:0]            h_scroll;

  // Model state
  logic [7:0]  regs [32];
  logic [7:0]  lat0, lat1, lat25, lat26;   // Taken at the last hsync
  logic [5:0]  r17_ptr;
  logic        r17_inc;
  logic [3:0]  pal_idx;
  logic [8:0]  pal_model [`PAL_ENTRIES];
  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int unsigned cycles;

  tb_clock_gen u_clock_gen (.RESET(RESET), .CLK21M(CLK21M));

  vdp_register u_dut (.*);

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Register below 28, skipping R15 to R17
  function automatic logic [5:0] pick_reg();
    logic [31:0] v;
    do begin
      v = rand_bits(5);
    end while (v[4:0] >= 28 || (v[4:0] >= 15 && v[4:0] <= 17));
    return {1'b0, v[4:0]};
  endfunction

  // m is {M5, M4, M3, M2, M1}; zero flags mark an undefined code
  function automatic mode_flags_t expect_flags(input logic [4:0] m);
    mode_flags_t f;
    f = '0;
    case (m)
      5'b00000: f.graphic1 = 1'b1;
      5'b00001: f.text1    = 1'b1;
      5'b00010: f.multi    = 1'b1;
      5'b00100: f.graphic2 = 1'b1;
      5'b00101: f.text1q   = 1'b1;
      5'b00110: f.multiq   = 1'b1;
      5'b01000: f.graphic3 = 1'b1;
      5'b01001: f.text2    = 1'b1;
      5'b01100: f.graphic4 = 1'b1;
      5'b10000: f.graphic5 = 1'b1;
      5'b10100: f.graphic6 = 1'b1;
      5'b11100: f.graphic7 = 1'b1;
      default: ;
    endcase
    f.is_high_res = f.graphic5 || f.graphic6;
    f.sp_mode2    = f.graphic3 || f.graphic4 || f.graphic5 || f.graphic6 || f.graphic7;
    return f;
  endfunction

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_fields();
    logic [6:0] exp_name;
    exp_name = regs[2][6:0];
    if ((lat0[3] || lat0[3:1] == 3'b011) && regs[9][2]) begin
      exp_name[5] = field;   // Two-page bitmap follows the field
    end
    check_val("flags", flags, expect_flags({lat0[3:1], lat1[3], lat1[4]}));
    check_val("disp_on", disp_on, lat1[6]);
    check_val("r0_hsync_int_en", r0_hsync_int_en, regs[0][4]);
    check_val("r1_sp_size", r1_sp_size, regs[1][1]);
    check_val("r1_sp_zoom", r1_sp_zoom, regs[1][0]);
    check_val("r1_vsync_int_en", r1_vsync_int_en, regs[1][5]);
    check_val("name_addr", name_addr, exp_name);
    check_val("color_addr", color_addr, {regs[10][2:0], regs[3]});
    check_val("pat_gen_addr", pat_gen_addr, regs[4][5:0]);
    check_val("sp_atr_addr", sp_atr_addr, {regs[11][1:0], regs[5]});
    check_val("sp_gen_addr", sp_gen_addr, regs[6][5:0]);
    check_val("frame_color", frame_color, regs[7]);
    check_val("r8_sp_off", r8_sp_off, regs[8][1]);
    check_val("r8_col0_on", r8_col0_on, regs[8][5]);
    check_val("r9_pal_mode", r9_pal_mode, regs[9][1]);
    check_val("r9_interlace", r9_interlace, regs[9][3]);
    check_val("r9_y_dots", r9_y_dots, regs[9][7]);
    check_val("blink_mode", blink_mode, regs[12]);
    check_val("blink_period", blink_period, regs[13]);
    check_val("adjust", adjust, regs[18]);
    check_val("hsync_int_line", hsync_int_line, regs[19]);
    check_val("vstart_line", vstart_line, regs[23]);
    check_val("r25_yae", r25_yae, regs[25][4]);
    check_val("r25_yjk", r25_yjk, regs[25][3]);
    check_val("r25_msk", r25_msk, regs[25][1]);
    check_val("r25_sp2", r25_sp2, lat25[0]);
    check_val("h_scroll", h_scroll, {lat26[5:0], regs[27][2:0]});
  endtask

  function automatic void model_write(input logic [5:0] num, input logic [7:0] d);
    if (!num[5]) begin
      regs[num[4:0]] = d;   // Command registers are not kept
    end
    if (num == 6'd17) begin
      r17_ptr = d[5:0];
      r17_inc = !d[7];
    end
    if (num == 6'd16) begin
      pal_idx = d[3:0];
    end
  endfunction

  function automatic void model_indirect(input logic [7:0] d);
    if (r17_ptr != 6'd17) begin
      model_write(r17_ptr, d);
    end
    if (r17_inc) begin
      r17_ptr = r17_ptr + 6'd1;
    end
  endfunction

  // One CPU cycle; ack is due one cycle after req and gone the next
  task automatic access(input logic w, input port_t p, input logic [7:0] d);
    req     = 1'b1;
    wrt     = w;
    port    = p;
    data_in = d;
    @(negedge RESET);
    req = 1'b0;
    check_val("ack", ack, 1'b1);
    @(negedge RESET);
    check_val("ack", ack, 1'b0);
  endtask

  task automatic write_reg(input logic [5:0] num, input logic [7:0] d);
    logic [31:0] v;
    v = rand_bits(1);
    access(1'b1, PORT_CTRL, d);
    access(1'b1, PORT_CTRL, {1'b1, v[0], num});   // 10 or 11 selects a register
    model_write(num, d);
  endtask

  task automatic hsync_pulse();
    logic [31:0] v;
    v     = rand_bits(1);
    hsync = 1'b1;
    field = v[0];
    @(negedge RESET);
    hsync = 1'b0;
    lat0  = regs[0];
    lat1  = regs[1];
    lat25 = regs[25];
    lat26 = regs[26];
  endtask

  task automatic wait_commit();
    logic [31:0] v;
    do begin
      v        = rand_bits(2);
      dotstate = v[1:0];
      @(negedge RESET);
    end while (dotstate != 2'b01 && dotstate != 2'b10);
  endtask

  task automatic read_palette();
    for (int i = 0; i < `PAL_ENTRIES; i++) begin
      pal_addr = i;
      @(negedge RESET);   // Registered read
      check_val($sformatf("pal_r[%0d]", i), pal_r, pal_model[i][8:6]);
      check_val($sformatf("pal_g[%0d]", i), pal_g, pal_model[i][5:3]);
      check_val($sformatf("pal_b[%0d]", i), pal_b, pal_model[i][2:0]);
    end
  endtask

  task automatic status_read(input logic [3:0] sel);
    logic [31:0] v;
    logic [7:0]  exp_data;
    v = rand_bits(7);
    write_reg(6'd15, {v[6:3], sel});
    vd    = v[2];
    hd    = v[1];
    field = v[0];
    access(1'b0, PORT_CTRL, 8'h00);
    case (sel)
      4'd1:    exp_data = {2'b00, `VDP_ID, 1'b0};
      4'd2:    exp_data = {1'b0, vd, hd, 1'b0, 2'b11, field, 1'b0};
      default: exp_data = `STATUS_FILL;
    endcase
    check_val("read_data", read_data, exp_data);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin : main
    logic [31:0] v;
    logic [4:0]  code;
    logic [5:0]  num;
    logic [47:0] pr, pg, pb;
    lfsr     = 32'h351e_8c88;
    req      = 1'b0;
    wrt      = 1'b0;
    port     = PORT_VRAM;
    data_in  = '0;
    hsync    = 1'b0;
    field    = 1'b0;
    vd       = 1'b0;
    hd       = 1'b0;
    dotstate = 2'b00;
    pal_addr = '0;
    errors   = 0;
    checks   = 0;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    lat0    = '0;
    lat1    = '0;
    lat25   = '0;
    lat26   = '0;
    r17_ptr = '0;
    r17_inc = 1'b0;
    pal_idx = '0;
    pr = `PAL_RESET_R;
    pg = `PAL_RESET_G;
    pb = `PAL_RESET_B;
    for (int i = 0; i < `PAL_ENTRIES; i++) begin
      pal_model[i] = {pr[3*i +: 3], pg[3*i +: 3], pb[3*i +: 3]};
    end
    @(negedge CLK21M);

    // Reset state
    check_val("ack", ack, 1'b0);
    check_fields();
    read_palette();

    // Direct writes with stray VRAM traffic
    for (int i = 0; i < N_DIRECT; i++) begin
      v = rand_bits(9);
      if (v[8]) begin
        access(1'b1, PORT_VRAM, v[7:0]);
        access(1'b1, PORT_CTRL, v[7:0]);
        access(1'b1, PORT_CTRL, {1'b0, v[6:0]});   // Address setup pair
      end
      num = pick_reg();
      v   = rand_bits(9);
      write_reg(num, v[7:0]);
      check_fields();
      if (v[8]) begin
        hsync_pulse();
        check_fields();
      end
    end

    // Mode latch and decode
    for (int i = 0; i < N_MODE; i++) begin
      do begin
        v = rand_bits(5);
      end while (expect_flags(v[4:0]) == '0);
      code = v[4:0];
      v    = rand_bits(16);
      write_reg(6'd0, {v[7:4], code[4:2], v[0]});
      write_reg(6'd1, {v[15:13], code[0], code[1], v[10:8]});
      v = rand_bits(8);
      write_reg(6'd9, v[7:0]);
      check_fields();   // Old mode until hsync
      hsync_pulse();
      check_fields();
    end

    // Indirect writes through R17
    for (int i = 0; i < N_IND; i++) begin
      v   = rand_bits(8);
      num = v[0] ? 6'd18 + v[7:1] % 6 : v[7:1] % 11;
      write_reg(6'd17, {2'b00, num});   // Auto-increment on
      repeat (4) begin
        v = rand_bits(8);
        access(1'b1, PORT_INDIRECT, v[7:0]);
        model_indirect(v[7:0]);
      end
      check_fields();
    end
    write_reg(6'd17, 8'h91);   // Points at R17, no increment
    // A leaked write here would aim R17 at R7 for the next byte
    access(1'b1, PORT_INDIRECT, 8'h07);
    model_indirect(8'h07);
    v = {24'h0, ~regs[7]};
    access(1'b1, PORT_INDIRECT, v[7:0]);
    model_indirect(v[7:0]);
    check_fields();

    // Palette, runs past the index wrap
    v = rand_bits(4);
    write_reg(6'd16, {4'h0, v[3:0]});
    for (int i = 0; i < N_PAL; i++) begin
      v = rand_bits(16);
      access(1'b1, PORT_PALETTE, v[7:0]);    // Red and blue
      access(1'b1, PORT_PALETTE, v[15:8]);   // Green
      pal_model[pal_idx] = {v[6:4], v[10:8], v[2:0]};
      pal_idx            = pal_idx + 4'd1;
      wait_commit();
    end
    read_palette();

    // Status reads, then a read between two bytes
    status_read(4'd1);
    status_read(4'd2);
    for (int i = 0; i < N_STAT; i++) begin
      v = rand_bits(12);
      status_read(v[3:0]);
      access(1'b1, PORT_CTRL, v[11:4]);   // Lone first byte
      access(1'b0, PORT_CTRL, 8'h00);
      num = pick_reg();
      v   = rand_bits(8);
      write_reg(num, v[7:0]);
      check_fields();
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  always @(posedge RESET) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: test did not finish in %0d cycles, errors: %0d", TIMEOUT, errors);
      $display("Regression failed");
      $finish;
    end
  end

endmodule

//--- sources.f
+incdir+include
source/vdp_reg_pkg.sv
source/vdp_mode_pkg.sv
source/cpu_port_decoder.sv
source/control_regs.sv
source/display_mode_decoder.sv
source/palette_writer.sv
source/status_reader.sv
source/vdp_register.sv
bench/tb_clock_gen.sv
bench/tb_vdp_register.sv
